/* all.f */
src/mipsPkg.sv
src/registerFile.sv
src/aluUnit.sv
src/mainController.sv
src/multiCycleCore.sv
src/memArbiter.sv
src/unifiedMemory.sv
src/cpuTop.sv
dv/cpuTb_properties.sv
dv/cpuTb.sv

/* dv/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    import mipsPkg::*;

    localparam int dataBase     = 8'h80;
    localparam int resultBase   = 8'hC0;
    localparam int scratchBase  = 8'hE0;
    localparam int scratchWords = 16;

    localparam logic [5:0] functList [6] = '{FUNCT_ADD, FUNCT_SUB, FUNCT_AND,
                                             FUNCT_OR, FUNCT_XOR, FUNCT_SLT};
    localparam opcode_t immOps [4] = '{OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    localparam logic [31:0] haltWord = {OP_HALT, 26'h0};

    logic                 Clk;
    logic                 reset;
    logic                 start;
    logic                 hostReq;
    logic                 hostWrite;
    logic [addrWidth-1:0] hostAddr;
    logic [dataWidth-1:0] hostWdata;
    logic                 hostGrant;
    logic [dataWidth-1:0] hostRdata;
    logic                 halted;

    logic [dataWidth-1:0] image   [memDepth];
    logic [dataWidth-1:0] refMem  [memDepth];
    logic [dataWidth-1:0] refRegs [32];
    logic [dataWidth-1:0] prog    [$];
    integer               seed;
    int                   cycleCount;
    int                   cycleLimit;
    int                   errorCount;
    bit                   firstLoad;
    bit                   compareReq;

    cpuTop dut (
        .Clk(Clk), .reset(reset), .start(start),
        .hostReq(hostReq), .hostWrite(hostWrite),
        .hostAddr(hostAddr), .hostWdata(hostWdata),
        .hostGrant(hostGrant), .hostRdata(hostRdata), .halted(halted)
    );

    always #50 Clk = ~Clk;

    //////////////////////////////////////////////////
    // Instruction encoding and reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] encodeR(int rs, int rt, int rd, logic [5:0] funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
    endfunction

    function automatic logic [31:0] encodeI(opcode_t op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // Runs refMem from address zero until a halt and counts the instructions
    function automatic int interpret();
        logic [addrWidth-1:0] pc;
        int                   steps;
        bit                   running;
        logic [31:0]          ins;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          sImm;
        logic [31:0]          zImm;
        logic [31:0]          res;
        pc      = '0;
        steps   = 0;
        running = 1'b1;
        while (running && steps < 5000)
        begin
            ins  = refMem[pc];
            pc   = pc + 1'b1;
            steps++;
            a    = refRegs[ins[25:21]];
            b    = refRegs[ins[20:16]];
            sImm = {{16{ins[15]}}, ins[15:0]};
            zImm = {16'h0, ins[15:0]};
            case (ins[31:26])
                OP_RTYPE:
                begin
                    case (ins[5:0])
                        FUNCT_SUB: res = a - b;
                        FUNCT_AND: res = a & b;
                        FUNCT_OR:  res = a | b;
                        FUNCT_XOR: res = a ^ b;
                        FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:   res = a + b;
                    endcase
                    refRegs[ins[15:11]] = res;
                end
                OP_LW:   refRegs[ins[20:16]] = refMem[8'(a + sImm)];
                OP_SW:   refMem[8'(a + sImm)] = b;
                OP_BEQ:
                begin
                    if (a == b)
                        pc = pc + 8'(sImm);
                end
                OP_J:    pc = ins[7:0];
                OP_ANDI: refRegs[ins[20:16]] = a & zImm;
                OP_ORI:  refRegs[ins[20:16]] = a | zImm;
                OP_XORI: refRegs[ins[20:16]] = a ^ zImm;
                OP_LUI:  refRegs[ins[20:16]] = zImm << 16;
                default: running = 1'b0;
            endcase
            refRegs[0] = '0;
        end
        return steps;
    endfunction

    //////////////////////////////////////////////////
    // Host port and checking
    //////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            errorCount++;
            $display("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Something failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic hostWriteWord(input logic [7:0] addr, input logic [31:0] data);
        @(posedge Clk);
        hostReq   <= 1'b1;
        hostWrite <= 1'b1;
        hostAddr  <= addr;
        hostWdata <= data;
        do
            @(negedge Clk);
        while (!hostGrant);
        @(posedge Clk);
        hostReq   <= 1'b0;
        hostWrite <= 1'b0;
    endtask

    task automatic hostReadWord(input logic [7:0] addr, output logic [31:0] data);
        @(posedge Clk);
        hostReq   <= 1'b1;
        hostWrite <= 1'b0;
        hostAddr  <= addr;
        do
            @(negedge Clk);
        while (!hostGrant);
        @(posedge Clk);
        hostReq <= 1'b0;
        // Read data arrives the cycle after the grant
        @(negedge Clk);
        data = hostRdata;
    endtask

    task automatic loadImage();
        logic [31:0] got;
        for (int i = 0; i < memDepth; i++)
            hostWriteWord(8'(i), image[i]);
        if (firstLoad)
        begin
            for (int i = 0; i < memDepth; i++)
            begin
                hostReadWord(8'(i), got);
                checkValue($sformatf("hostRdata[0x%02h]", i), got, image[i]);
            end
            firstLoad = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // Programs
    //////////////////////////////////////////////////
    task automatic prepareImage();
        prog.delete();
        for (int i = 0; i < memDepth; i++)
            image[i] = {8'h5A, 4'h0, 8'(i), 4'h0, 8'(i)};
    endtask

    task automatic buildRtypeProgram();
        int slot;
        prepareImage();
        slot = 0;
        for (int k = 0; k < 4; k++)
        begin
            image[dataBase + k] = $random(seed);
            prog.push_back(encodeI(OP_LW, 0, k + 1, 16'(dataBase + k)));
        end
        for (int p = 0; p < 2; p++)
        begin
            for (int f = 0; f < 6; f++)
            begin
                prog.push_back(encodeR(2 * p + 1, 2 * p + 2, 5 + f, functList[f]));
                prog.push_back(encodeI(OP_SW, 0, 5 + f, 16'(resultBase + slot)));
                slot++;
            end
        end
        // Swapped operands for the other slt outcome
        prog.push_back(encodeR(2, 1, 11, FUNCT_SLT));
        prog.push_back(encodeI(OP_SW, 0, 11, 16'(resultBase + slot)));
        prog.push_back(haltWord);
    endtask

    task automatic buildImmProgram();
        logic [15:0] imm;
        int          slot;
        prepareImage();
        slot = 0;
        image[dataBase]     = $random(seed);
        image[dataBase + 1] = $random(seed);
        prog.push_back(encodeI(OP_LW, 0, 1, 16'(dataBase)));
        prog.push_back(encodeI(OP_LW, 0, 2, 16'(dataBase + 1)));
        for (int k = 0; k < 4; k++)
        begin
            for (int src = 1; src <= 2; src++)
            begin
                imm = 16'($random(seed));
                // Top bit set shows zero extension
                if (src == 2)
                    imm[15] = 1'b1;
                prog.push_back(encodeI(immOps[k], src, 12 + slot, imm));
                prog.push_back(encodeI(OP_SW, 0, 12 + slot, 16'(resultBase + slot)));
                slot++;
            end
        end
        prog.push_back(haltWord);
    endtask

    task automatic buildLoopProgram(input int count);
        int loopAt;
        prepareImage();
        for (int k = 0; k < 4; k++)
        begin
            image[dataBase + k] = $random(seed);
            prog.push_back(encodeI(OP_LW, 0, k + 1, 16'(dataBase + k)));
            prog.push_back(encodeI(OP_SW, 0, k + 1, 16'(resultBase + 8 + k)));
        end
        prog.push_back(encodeI(OP_ORI, 0, 20, 16'(count)));
        prog.push_back(encodeR(0, 0, 21, FUNCT_AND));
        prog.push_back(encodeI(OP_ORI, 0, 22, 16'd1));
        loopAt = prog.size();
        // Exit skips the add and the jump back
        prog.push_back(encodeI(OP_BEQ, 21, 20, 16'd2));
        prog.push_back(encodeR(21, 22, 21, FUNCT_ADD));
        prog.push_back({OP_J, 26'(loopAt)});
        prog.push_back(encodeI(OP_SW, 0, 21, 16'(resultBase)));
        prog.push_back(haltWord);
    endtask

    task automatic runProgram(input int trafficWords);
        int          steps;
        logic [31:0] value;
        logic [31:0] got;
        for (int i = 0; i < prog.size(); i++)
            image[i] = prog[i];
        refMem = image;
        steps  = interpret();
        cycleLimit += steps * 5 + (3 * memDepth + 2 * trafficWords) * 3 + 100;
        loadImage();
        @(posedge Clk);
        start <= 1'b1;
        do
            @(negedge Clk);
        while (halted);
        // Scratch traffic while the core runs
        for (int k = 0; k < trafficWords; k++)
        begin
            value = $random(seed);
            refMem[scratchBase + k] = value;
            hostWriteWord(8'(scratchBase + k), value);
        end
        for (int k = 0; k < trafficWords; k++)
        begin
            hostReadWord(8'(scratchBase + k), got);
            checkValue($sformatf("hostRdata[0x%02h]", scratchBase + k), got,
                       refMem[scratchBase + k]);
        end
        do
            @(negedge Clk);
        while (!halted);
        repeat (8) @(negedge Clk);
        checkValue("halted", {31'b0, halted}, 32'd1);
        @(posedge Clk);
        start <= 1'b0;
        compareReq = 1'b1;
        wait (!compareReq);
    endtask

    // Reads the whole memory back after a halt
    initial
    begin
        logic [31:0] got;
        forever
        begin
            wait (compareReq);
            for (int i = 0; i < memDepth; i++)
            begin
                hostReadWord(8'(i), got);
                checkValue($sformatf("hostRdata[0x%02h]", i), got, refMem[i]);
            end
            compareReq = 1'b0;
        end
    end

    // Watchdog
    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("Watchdog expired after %0d cycles, the run did not finish", cycleCount);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

    initial
    begin
        Clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        hostReq    = 1'b0;
        hostWrite  = 1'b0;
        hostAddr   = '0;
        hostWdata  = '0;
        seed       = 90;
        cycleCount = 0;
        cycleLimit = 50;
        errorCount = 0;
        firstLoad  = 1'b1;
        compareReq = 1'b0;
        for (int r = 0; r < 32; r++)
            refRegs[r] = '0;
        repeat (2) @(posedge Clk);
        reset <= 1'b0;
        @(negedge Clk);
        checkValue("halted", {31'b0, halted}, 32'd0);
        checkValue("hostGrant", {31'b0, hostGrant}, 32'd0);

        // Registers carry over between programs in the DUT and the model alike
        buildRtypeProgram();
        runProgram(0);
        buildLoopProgram(5);
        runProgram(0);
        buildLoopProgram(25);
        runProgram(scratchWords);
        buildRtypeProgram();
        runProgram(0);
        buildImmProgram();
        runProgram(0);

        if (errorCount == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* dv/cpuTb_properties.sv */
`timescale 1ns/1ps

module cpuTbProperties
(
    input logic Clk,
    input logic reset,
    input logic hostGrant,
    input logic coreReq,
    input logic coreGrant,
    input logic halted
);

    // One owner of the memory per cycle
    grantsExclusive: assert property (@(posedge Clk) disable iff (reset)
        !(hostGrant && coreGrant))
        else $error("host and core granted in the same cycle");

    coreGrantNeedsReq: assert property (@(posedge Clk) disable iff (reset)
        coreGrant |-> coreReq)
        else $error("core grant without core request");

    // A halted core stays off the memory
    haltedIdle: assert property (@(posedge Clk) disable iff (reset)
        halted |-> !coreReq)
        else $error("memory request while halted");

endmodule

bind cpuTop cpuTbProperties props (
    .Clk(Clk), .reset(reset), .hostGrant(hostGrant),
    .coreReq(coreReq), .coreGrant(coreGrant), .halted(halted)
);

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module cpuTb -f all.f -o simCpu
./obj_dir/simCpu 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation FAILED, no pass message in sim.log"
    exit 1
fi
echo "Simulation PASSED"

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit
(
    input  mipsPkg::aluOp_t                  aluOp,
    input  logic [5:0]                       funct,
    input  logic [1:0]                       opLow,
    input  logic [mipsPkg::dataWidth-1:0]    a,
    input  logic [mipsPkg::dataWidth-1:0]    b,
    output logic [mipsPkg::dataWidth-1:0]    result,
    output logic                             zero
);
    import mipsPkg::*;

    aluFunc_t func;

    // Function select
    always_comb
    begin
        unique case (aluOp)
            ALUOP_ADD: func = ADD;
            ALUOP_SUB: func = SUB;
            ALUOP_FUNCT:
            begin
                case (funct)
                    FUNCT_SUB: func = SUB;
                    FUNCT_AND: func = AND;
                    FUNCT_OR:  func = OR;
                    FUNCT_XOR: func = XOR;
                    FUNCT_SLT: func = SLT;
                    default:   func = ADD;
                endcase
            end
            // andi, ori, xori, lui differ only in the two low opcode bits
            ALUOP_IMM:
            begin
                case (opLow)
                    2'b00:   func = AND;
                    2'b01:   func = OR;
                    2'b10:   func = XOR;
                    default: func = LUI;
                endcase
            end
            default:   func = ADD;
        endcase
    end

    always_comb
    begin
        case (func)
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            LUI:     result = b << 16;
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* src/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop
(
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             hostReq,
    input  logic                             hostWrite,
    input  logic [mipsPkg::addrWidth-1:0]    hostAddr,
    input  logic [mipsPkg::dataWidth-1:0]    hostWdata,
    output logic                             hostGrant,
    output logic [mipsPkg::dataWidth-1:0]    hostRdata,
    output logic                             halted
);
    import mipsPkg::*;

    logic                 coreReq, coreWrite, coreGrant, memEn, memWe;
    logic [addrWidth-1:0] coreAddr, memAddr;
    logic [dataWidth-1:0] coreWdata, coreRdata, memWdata, memRdata;

    multiCycleCore core (
        .Clk(Clk), .reset(reset), .start(start),
        .memGrant(coreGrant), .memRdata(coreRdata),
        .memReq(coreReq), .memWrite(coreWrite),
        .memAddr(coreAddr), .memWdata(coreWdata), .halted(halted)
    );

    // Host port and core share one memory
    memArbiter arbiter (
        .Clk(Clk), .reset(reset),
        .hostReq(hostReq), .hostWrite(hostWrite),
        .hostAddr(hostAddr), .hostWdata(hostWdata),
        .coreReq(coreReq), .coreWrite(coreWrite),
        .coreAddr(coreAddr), .coreWdata(coreWdata),
        .memRdata(memRdata),
        .hostGrant(hostGrant), .coreGrant(coreGrant),
        .hostRdata(hostRdata), .coreRdata(coreRdata),
        .memEn(memEn), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
    );

    unifiedMemory memory (
        .Clk(Clk), .en(memEn), .we(memWe), .addr(memAddr),
        .wdata(memWdata), .rdata(memRdata)
    );

endmodule

/* src/mainController.sv */
`timescale 1ns/1ps

module mainController
(
    input  logic              Clk,
    input  logic              reset,
    input  logic              start,
    input  mipsPkg::opcode_t  op,
    input  logic              zero,
    input  logic              memGrant,
    output logic              pcWrite,
    output logic              pcWriteCond,
    output logic              iorD,
    output logic              memReq,
    output logic              memWrite,
    output logic              irWrite,
    output logic              memToReg,
    output logic              regDst,
    output logic              regWrite,
    output logic              aluSrcA,
    output logic [1:0]        aluSrcB,
    output mipsPkg::aluOp_t   aluOp,
    output logic [1:0]        pcSource,
    output logic              halted
);
    import mipsPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       startPrev;
    logic       startRise;
    logic       granted;

    assign startRise = start & ~startPrev;
    assign granted   = memReq & memGrant;
    assign halted    = (state == HALT);

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            state     <= FETCH;
            startPrev <= 1'b0;
        end
        else
        begin
            state     <= nextState;
            startPrev <= start;
        end
    end

    //////////////////////////////////////////////////
    // Outputs and next state
    //////////////////////////////////////////////////
    always_comb
    begin
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        iorD        = 1'b0;
        memReq      = 1'b0;
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        memToReg    = 1'b0;
        regDst      = 1'b0;
        regWrite    = 1'b0;
        aluSrcA     = 1'b0;
        aluSrcB     = 2'd1;
        aluOp       = ALUOP_ADD;
        pcSource    = 2'd0;
        nextState   = state;
        unique case (state)
            FETCH:
            begin
                // Fetch only while start is held high
                memReq  = start;
                pcWrite = granted;
                if (granted)
                    nextState = DECODE;
            end
            DECODE:
            begin
                // Branch target PC+1+imm lands in ALUOut
                irWrite = 1'b1;
                aluSrcB = 2'd3;
                case (op)
                    OP_LW, OP_SW:                     nextState = MEMADDR;
                    OP_RTYPE:                         nextState = RTYPEEXEC;
                    OP_BEQ:                           nextState = BRANCH;
                    OP_J:                             nextState = JUMP;
                    OP_ANDI, OP_ORI, OP_XORI, OP_LUI: nextState = IMMEXEC;
                    default:                          nextState = HALT;
                endcase
            end
            MEMADDR, MEMREAD, MEMWRITE:
            begin
                // ALU inputs held so ALUOut keeps the address through a stall
                aluSrcA = 1'b1;
                aluSrcB = 2'd2;
                if (state == MEMADDR)
                    nextState = (op == OP_LW) ? MEMREAD : MEMWRITE;
                else
                begin
                    memReq   = 1'b1;
                    iorD     = 1'b1;
                    memWrite = (state == MEMWRITE);
                    if (granted)
                        nextState = (state == MEMREAD) ? MEMWRITEBACK : FETCH;
                end
            end
            MEMWRITEBACK:
            begin
                regWrite  = 1'b1;
                memToReg  = 1'b1;
                nextState = FETCH;
            end
            RTYPEEXEC, RTYPEWRITEBACK:
            begin
                aluSrcA   = 1'b1;
                aluSrcB   = 2'd0;
                aluOp     = ALUOP_FUNCT;
                regDst    = 1'b1;
                regWrite  = (state == RTYPEWRITEBACK);
                nextState = (state == RTYPEEXEC) ? RTYPEWRITEBACK : FETCH;
            end
            IMMEXEC, IMMWRITEBACK:
            begin
                aluSrcA   = 1'b1;
                aluSrcB   = 2'd2;
                aluOp     = ALUOP_IMM;
                regWrite  = (state == IMMWRITEBACK);
                nextState = (state == IMMEXEC) ? IMMWRITEBACK : FETCH;
            end
            BRANCH:
            begin
                // Taken only when the operands are equal
                aluSrcA     = 1'b1;
                aluSrcB     = 2'd0;
                aluOp       = ALUOP_SUB;
                pcWriteCond = zero;
                pcSource    = 2'd1;
                nextState   = FETCH;
            end
            JUMP:
            begin
                pcWrite   = 1'b1;
                pcSource  = 2'd2;
                nextState = FETCH;
            end
            HALT:
            begin
                // New start edge restarts the program from address zero
                if (startRise)
                begin
                    pcWrite   = 1'b1;
                    pcSource  = 2'd3;
                    nextState = FETCH;
                end
            end
            default: nextState = HALT;
        endcase
    end

endmodule

/* src/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter
(
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             hostReq,
    input  logic                             hostWrite,
    input  logic [mipsPkg::addrWidth-1:0]    hostAddr,
    input  logic [mipsPkg::dataWidth-1:0]    hostWdata,
    input  logic                             coreReq,
    input  logic                             coreWrite,
    input  logic [mipsPkg::addrWidth-1:0]    coreAddr,
    input  logic [mipsPkg::dataWidth-1:0]    coreWdata,
    input  logic [mipsPkg::dataWidth-1:0]    memRdata,
    output logic                             hostGrant,
    output logic                             coreGrant,
    output logic [mipsPkg::dataWidth-1:0]    hostRdata,
    output logic [mipsPkg::dataWidth-1:0]    coreRdata,
    output logic                             memEn,
    output logic                             memWe,
    output logic [mipsPkg::addrWidth-1:0]    memAddr,
    output logic [mipsPkg::dataWidth-1:0]    memWdata
);
    import mipsPkg::*;

    logic                 hostReadOwner, coreReadOwner;
    logic [dataWidth-1:0] hostHeld, coreHeld;

    // Host always wins
    assign hostGrant = hostReq;
    assign coreGrant = coreReq & ~hostReq;

    assign memEn    = hostGrant | coreGrant;
    assign memWe    = hostGrant ? hostWrite : (coreGrant & coreWrite);
    assign memAddr  = hostGrant ? hostAddr : coreAddr;
    assign memWdata = hostGrant ? hostWdata : coreWdata;

    //////////////////////////////////////////////////
    // Read return routing
    //////////////////////////////////////////////////
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            hostReadOwner <= 1'b0;
            coreReadOwner <= 1'b0;
        end
        else
        begin
            hostReadOwner <= hostGrant & ~hostWrite;
            coreReadOwner <= coreGrant & ~coreWrite;
        end
    end

    assign hostRdata = hostReadOwner ? memRdata : hostHeld;
    assign coreRdata = coreReadOwner ? memRdata : coreHeld;

    always_ff @(posedge Clk)
    begin
        hostHeld <= hostRdata;
        coreHeld <= coreRdata;
    end

endmodule

/* src/mipsPkg.sv */
package mipsPkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int dataWidth    = 32;
    localparam int addrWidth    = 8;
    localparam int memDepth     = 256;
    localparam int regAddrWidth = 5;

    // R-type funct field values
    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_XOR = 6'h26;
    localparam logic [5:0] FUNCT_SLT = 6'h2A;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F
    } opcode_t;

    typedef enum logic [3:0] {
        FETCH, DECODE, MEMADDR, MEMREAD, MEMWRITEBACK, MEMWRITE, RTYPEEXEC,
        RTYPEWRITEBACK, BRANCH, JUMP, IMMEXEC, IMMWRITEBACK, HALT
    } ctrlState_t;

    typedef enum logic [1:0] {ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT, ALUOP_IMM} aluOp_t;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT, LUI} aluFunc_t;

endpackage

/* src/multiCycleCore.sv */
`timescale 1ns/1ps

module multiCycleCore
(
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             memGrant,
    input  logic [mipsPkg::dataWidth-1:0]    memRdata,
    output logic                             memReq,
    output logic                             memWrite,
    output logic [mipsPkg::addrWidth-1:0]    memAddr,
    output logic [mipsPkg::dataWidth-1:0]    memWdata,
    output logic                             halted
);
    import mipsPkg::*;

    logic [dataWidth-1:0] pc, ir, mdr, regA, regB, aluOut;
    logic [dataWidth-1:0] memWord, instr, signImm, zeroImm, srcA, srcB;
    logic [dataWidth-1:0] aluResult, nextPc, writeData, readData1, readData2;
    logic                 rdValid, zero, isLogicOp;
    logic                 pcWrite, pcWriteCond, iorD, irWrite, memToReg;
    logic                 regDst, regWrite, aluSrcA;
    logic [1:0]           aluSrcB, pcSource;
    aluOp_t               aluOp;
    opcode_t              opcode;

    //////////////////////////////////////////////////
    // Instruction and immediates
    //////////////////////////////////////////////////
    // MDR keeps the core's last read word between returns
    assign memWord   = rdValid ? memRdata : mdr;
    // Decode sees the fetched word in the same cycle it enters IR
    assign instr     = irWrite ? memWord : ir;
    assign opcode    = opcode_t'(instr[31:26]);
    assign isLogicOp = opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    assign signImm   = {{16{instr[15]}}, instr[15:0]};
    assign zeroImm   = {16'b0, instr[15:0]};

    // Operand and PC muxes
    assign srcA = aluSrcA ? regA : pc;
    always_comb
    begin
        case (aluSrcB)
            2'd0:    srcB = regB;
            2'd1:    srcB = 32'd1;
            2'd2:    srcB = isLogicOp ? zeroImm : signImm;
            default: srcB = signImm;
        endcase
        case (pcSource)
            2'd0:    nextPc = aluResult;
            2'd1:    nextPc = aluOut;
            2'd2:    nextPc = {pc[31:26], ir[25:0]};
            default: nextPc = '0;
        endcase
    end

    assign writeData = memToReg ? memWord : aluOut;
    assign memAddr   = iorD ? aluOut[addrWidth-1:0] : pc[addrWidth-1:0];
    assign memWdata  = regB;

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            pc      <= '0;
            rdValid <= 1'b0;
        end
        else
        begin
            if (pcWrite || pcWriteCond)
                pc <= nextPc;
            rdValid <= memReq & ~memWrite & memGrant;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (irWrite)
            ir <= memWord;
        mdr    <= memWord;
        regA   <= readData1;
        regB   <= readData2;
        aluOut <= aluResult;
    end

    mainController controller (
        .Clk(Clk), .reset(reset), .start(start), .op(opcode), .zero(zero),
        .memGrant(memGrant), .pcWrite(pcWrite), .pcWriteCond(pcWriteCond),
        .iorD(iorD), .memReq(memReq), .memWrite(memWrite), .irWrite(irWrite),
        .memToReg(memToReg), .regDst(regDst), .regWrite(regWrite),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
        .pcSource(pcSource), .halted(halted)
    );

    aluUnit alu (
        .aluOp(aluOp), .funct(instr[5:0]), .opLow(instr[27:26]),
        .a(srcA), .b(srcB), .result(aluResult), .zero(zero)
    );

    registerFile regFile (
        .Clk(Clk), .reset(reset),
        .readAddr1(instr[25:21]), .readAddr2(instr[20:16]),
        .writeAddr(regDst ? ir[15:11] : ir[20:16]),
        .writeEnable(regWrite), .writeData(writeData),
        .readData1(readData1), .readData2(readData2)
    );

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile
(
    input  logic                               Clk,
    input  logic                               reset,
    input  logic [mipsPkg::regAddrWidth-1:0]   readAddr1,
    input  logic [mipsPkg::regAddrWidth-1:0]   readAddr2,
    input  logic [mipsPkg::regAddrWidth-1:0]   writeAddr,
    input  logic                               writeEnable,
    input  logic [mipsPkg::dataWidth-1:0]      writeData,
    output logic [mipsPkg::dataWidth-1:0]      readData1,
    output logic [mipsPkg::dataWidth-1:0]      readData2
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**regAddrWidth; i++)
                regs[i] <= '0;
        end
        else if (writeEnable && writeAddr != '0)
            regs[writeAddr] <= writeData;
    end

    // r0 is hardwired to zero
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* src/unifiedMemory.sv */
`timescale 1ns/1ps

module unifiedMemory
(
    input  logic                             Clk,
    input  logic                             en,
    input  logic                             we,
    input  logic [mipsPkg::addrWidth-1:0]    addr,
    input  logic [mipsPkg::dataWidth-1:0]    wdata,
    output logic [mipsPkg::dataWidth-1:0]    rdata
);
    import mipsPkg::*;

    logic [dataWidth-1:0] mem [memDepth];

    // Reads return on the following cycle
    always_ff @(posedge Clk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];
        end
    end

endmodule
